// ==== rtl/qla_addr_pkg.sv ====
package qla_addr_pkg;

    // ------------------------------
    // bus widths and address fields
    // ------------------------------
    localparam int unsigned ADDR_W  = 16;
    localparam int unsigned DATA_W  = 32;
    localparam int unsigned SPACE_W = 4;   // addr[15:12]
    localparam int unsigned CHAN_W  = 4;   // addr[7:4]
    localparam int unsigned OFF_W   = 4;   // addr[3:0]

    typedef logic [ADDR_W-1:0]  reg_addr_t;
    typedef logic [DATA_W-1:0]  reg_data_t;
    typedef logic [SPACE_W-1:0] space_t;
    typedef logic [CHAN_W-1:0]  chan_t;
    typedef logic [OFF_W-1:0]   off_t;

    localparam space_t ADDR_MAIN = 4'd0;   // only decoded space

    // per-channel offsets
    localparam off_t OFF_BOARD_STATUS = 4'd0;   // channel 0 only
    localparam off_t OFF_ADC_DATA     = 4'd0;   // channels 1..4
    localparam off_t OFF_DAC_CTRL     = 4'd1;
    localparam off_t OFF_MOTOR_STATUS = 4'd12;

    // status word bit positions
    localparam int unsigned BIT_PWR_ENABLE    = 19;
    localparam int unsigned BIT_SAFETY_DIS_LO = 8;    // 11:8
    localparam int unsigned BIT_BOARD_ID_LO   = 24;   // 27:24
    localparam int unsigned BIT_AMP_ENABLED   = 28;   // motor status

    // field extraction, shared by all decoders
    function automatic space_t addr_space(reg_addr_t a);
        return a[ADDR_W-1 -: SPACE_W];
    endfunction

    function automatic chan_t addr_chan(reg_addr_t a);
        return a[OFF_W +: CHAN_W];
    endfunction

    function automatic off_t addr_off(reg_addr_t a);
        return a[OFF_W-1:0];
    endfunction

    // bits 11:8 always zero
    function automatic reg_addr_t make_addr(space_t space, chan_t chan, off_t off);
        return {space, {(ADDR_W-SPACE_W-CHAN_W-OFF_W){1'b0}}, chan, off};
    endfunction

endpackage

// ==== rtl/qla_motor_pkg.sv ====
package qla_motor_pkg;

    // ------------------------------
    // axes and current encoding
    // ------------------------------
    localparam int unsigned NUM_CHANNELS = 4;
    localparam int unsigned CHAN_IDX_W   = $clog2(NUM_CHANNELS);
    localparam int unsigned CUR_W        = 16;

    typedef logic [CHAN_IDX_W-1:0]   idx_t;        // zero-based axis index
    typedef logic [NUM_CHANNELS-1:0] axis_mask_t;  // one bit per axis
    typedef logic [CUR_W-1:0]        cur_t;        // offset binary
    typedef cur_t [NUM_CHANNELS-1:0] cur_vec_t;    // axis 1 in slot 0

    localparam cur_t CUR_MIDSCALE = 16'h8000;   // zero current

    // ------------------------------
    // safety limit
    // ------------------------------
    // fb magnitude must stay within 2*|cmd| + margin
    localparam cur_t SAFETY_MARGIN = 16'h0400;

    // two extra bits, 2*|cmd| + margin never wraps
    typedef logic [CUR_W+1:0] mag_t;

    // quadlet index that closes a real-time block
    localparam int unsigned RT_LAST_IDX = 3;

endpackage

// ==== rtl/safety_check.sv ====
`timescale 1ns/1ps

module safety_check
    import qla_motor_pkg::*;
(
    input  logic clk_125MHz,
    input  logic rst,
    input  cur_t cur_fb,
    input  cur_t cur_cmd,
    input  logic cur_fb_valid,
    input  logic clear_disable,
    output logic amp_disable
);

    mag_t fb_mag;
    mag_t cmd_mag;
    mag_t limit;
    logic over;

    // distance from midscale, max 16'h8000
    function automatic mag_t dist_mid(cur_t v);
        cur_t d;
        d = (v >= CUR_MIDSCALE) ? v - CUR_MIDSCALE : CUR_MIDSCALE - v;
        return mag_t'(d);
    endfunction

    // ------------------------------
    // overcurrent compare
    // ------------------------------
    assign fb_mag  = dist_mid(cur_fb);
    assign cmd_mag = dist_mid(cur_cmd);
    assign limit   = (cmd_mag << 1) + mag_t'(SAFETY_MARGIN);   // 2*|cmd| + margin
    assign over    = cur_fb_valid && (fb_mag > limit);          // only on a fresh sample

    always_ff @(posedge clk_125MHz) begin
        if (rst) begin
            amp_disable <= 1'b0;
        end else if (clear_disable) begin
            amp_disable <= 1'b0;   // clear beats a trip
        end else if (over) begin
            amp_disable <= 1'b1;   // sticky
        end
    end

endmodule

// ==== rtl/rt_block_writer.sv ====
`timescale 1ns/1ps

module rt_block_writer
    import qla_addr_pkg::*;
    import qla_motor_pkg::*;
(
    input  logic      clk_125MHz,
    input  logic      rst,
    input  logic      host_wen,
    input  logic      host_blk_wen,
    input  reg_addr_t host_waddr,
    input  reg_data_t host_wdata,
    input  logic      rt_wen,
    input  off_t      rt_waddr,     // quadlet index, axis = index + 1
    input  reg_data_t rt_wdata,
    output logic      reg_wen,
    output logic      blk_wen,
    output reg_addr_t reg_waddr,
    output reg_data_t reg_wdata
);

    cur_t rt_buf [NUM_CHANNELS];   // one command per axis
    logic replaying;               // replay owns the write bus
    idx_t replay_idx;
    logic rt_start;

    assign rt_start = rt_wen && (rt_waddr == off_t'(RT_LAST_IDX));

    // capture quadlets, last one lands on the same edge that starts replay
    always_ff @(posedge clk_125MHz) begin
        if (rt_wen && (rt_waddr < off_t'(NUM_CHANNELS))) begin
            rt_buf[idx_t'(rt_waddr)] <= rt_wdata[CUR_W-1:0];
        end
    end

    // ------------------------------
    // replay counter, 4 cycles
    // ------------------------------
    always_ff @(posedge clk_125MHz) begin
        if (rst) begin
            replaying  <= 1'b0;
            replay_idx <= '0;
        end else if (rt_start) begin
            replaying  <= 1'b1;   // new block restarts
            replay_idx <= '0;
        end else if (replaying) begin
            replay_idx <= replay_idx + idx_t'(1);
            if (replay_idx == idx_t'(RT_LAST_IDX)) begin
                replaying <= 1'b0;
            end
        end
    end

    // bus merge, host is dropped while replaying
    always_comb begin
        if (replaying) begin
            reg_wen   = 1'b1;
            blk_wen   = (replay_idx == idx_t'(RT_LAST_IDX));   // last write only
            reg_waddr = make_addr(ADDR_MAIN, chan_t'(replay_idx) + chan_t'(1), OFF_DAC_CTRL);
            reg_wdata = reg_data_t'(rt_buf[replay_idx]);
        end else begin
            reg_wen   = host_wen;
            blk_wen   = host_blk_wen;
            reg_waddr = host_waddr;
            reg_wdata = host_wdata;
        end
    end

    // host has no back-pressure, such a write is lost
    a_no_host_wr_in_replay: assert property (@(posedge clk_125MHz) disable iff (rst)
        replaying |-> !(host_wen || host_blk_wen))
        else $error("host write dropped during real-time replay");

endmodule

// ==== rtl/cur_cmd_regs.sv ====
`timescale 1ns/1ps

module cur_cmd_regs
    import qla_addr_pkg::*;
    import qla_motor_pkg::*;
(
    input  logic      clk_125MHz,
    input  logic      rst,
    input  logic      reg_wen,
    input  logic      blk_wen,
    input  reg_addr_t reg_waddr,
    input  reg_data_t reg_wdata,
    input  logic      dac_busy,
    output cur_vec_t  cur_cmd,
    output logic      dac_update
);

    chan_t ch;
    idx_t  ax;
    logic  ch_valid;
    logic  cmd_wr;
    logic  cmd_req;   // update pending, waits out dac_busy

    // ------------------------------
    // write decode
    // ------------------------------
    assign ch       = addr_chan(reg_waddr);
    assign ax       = idx_t'(ch - chan_t'(1));
    assign ch_valid = (ch != chan_t'(0)) && (ch <= chan_t'(NUM_CHANNELS));   // skip chan 0

    assign cmd_wr = reg_wen
                 && (addr_space(reg_waddr) == ADDR_MAIN)
                 && ch_valid
                 && (addr_off(reg_waddr) == OFF_DAC_CTRL);

    always_ff @(posedge clk_125MHz) begin
        if (rst) begin
            cur_cmd    <= {NUM_CHANNELS{CUR_MIDSCALE}};   // zero current
            cmd_req    <= 1'b0;
            dac_update <= 1'b0;
        end else begin
            if (cmd_wr) begin
                cur_cmd[ax] <= reg_wdata[CUR_W-1:0];
                cmd_req     <= blk_wen;   // only block writes kick the dac
            end else if (cmd_req && !dac_busy) begin
                cmd_req <= 1'b0;   // several requests coalesce into one pulse
            end
            dac_update <= cmd_req && !dac_busy;
        end
    end

    // dac must be idle whenever an update pulse reaches it
    a_update_when_idle: assert property (@(posedge clk_125MHz) disable iff (rst)
        dac_update |-> !dac_busy)
        else $error("dac_update while dac_busy");

endmodule

// ==== rtl/board_regs.sv ====
`timescale 1ns/1ps

module board_regs
    import qla_addr_pkg::*;
    import qla_motor_pkg::*;
(
    input  logic       clk_125MHz,
    input  logic       rst,
    input  logic       reg_wen,
    input  reg_addr_t  reg_waddr,
    input  reg_data_t  reg_wdata,
    input  cur_vec_t   cur_fb,
    input  cur_vec_t   cur_cmd,
    input  logic       cur_fb_valid,
    output axis_mask_t safety_disable,
    output logic       pwr_enable,
    output axis_mask_t amp_enable,
    output axis_mask_t clear_disable
);

    axis_mask_t amp_en_reg;   // host requested enables
    logic       board_wr;

    // channel 0 status register write
    assign board_wr = reg_wen
                   && (addr_space(reg_waddr) == ADDR_MAIN)
                   && (addr_chan(reg_waddr) == chan_t'(0))
                   && (addr_off(reg_waddr) == OFF_BOARD_STATUS);

    always_ff @(posedge clk_125MHz) begin
        if (rst) begin
            pwr_enable <= 1'b0;
            amp_en_reg <= '0;
        end else if (board_wr) begin
            pwr_enable <= reg_wdata[BIT_PWR_ENABLE];
            amp_en_reg <= reg_wdata[NUM_CHANNELS-1:0];
        end
    end

    // writing an enable (or power) re-arms that axis
    assign clear_disable = board_wr ?
        (reg_wdata[NUM_CHANNELS-1:0] | {NUM_CHANNELS{reg_wdata[BIT_PWR_ENABLE]}}) : '0;

    // ------------------------------
    // per-axis overcurrent latches
    // ------------------------------
    for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_axis
        safety_check i_safety_check (
            .clk_125MHz   (clk_125MHz),
            .rst          (rst),
            .cur_fb       (cur_fb[n]),
            .cur_cmd      (cur_cmd[n]),
            .cur_fb_valid (cur_fb_valid),
            .clear_disable(clear_disable[n]),
            .amp_disable  (safety_disable[n])
        );
    end

    assign amp_enable = amp_en_reg & ~safety_disable;   // latch overrides host

endmodule

// ==== rtl/reg_read_mux.sv ====
`timescale 1ns/1ps

module reg_read_mux
    import qla_addr_pkg::*;
    import qla_motor_pkg::*;
(
    input  logic       clk_125MHz,
    input  logic       rst,
    input  reg_addr_t  reg_raddr,
    input  logic [3:0] board_id,
    input  logic       pwr_enable,
    input  axis_mask_t amp_enable,
    input  axis_mask_t safety_disable,
    input  cur_vec_t   cur_fb,
    input  cur_vec_t   pot_fb,
    input  cur_vec_t   cur_cmd,
    output reg_data_t  reg_rdata
);

    chan_t     ch;
    off_t      off;
    idx_t      ax;
    logic      ch_valid;
    reg_data_t rd_next;

    assign ch       = addr_chan(reg_raddr);
    assign off      = addr_off(reg_raddr);
    assign ax       = idx_t'(ch - chan_t'(1));
    assign ch_valid = (ch != chan_t'(0)) && (ch <= chan_t'(NUM_CHANNELS));

    // ------------------------------
    // read decode, zero by default
    // ------------------------------
    always_comb begin
        rd_next = '0;
        if (addr_space(reg_raddr) == ADDR_MAIN) begin
            if (ch == chan_t'(0)) begin
                if (off == OFF_BOARD_STATUS) begin
                    rd_next[BIT_BOARD_ID_LO +: 4]              = board_id;
                    rd_next[BIT_PWR_ENABLE]                    = pwr_enable;
                    rd_next[BIT_SAFETY_DIS_LO +: NUM_CHANNELS] = safety_disable;
                    rd_next[NUM_CHANNELS-1:0]                  = amp_enable;
                end
            end else if (ch_valid) begin
                case (off)
                    OFF_ADC_DATA:  rd_next = {pot_fb[ax], cur_fb[ax]};   // pot high, cur low
                    OFF_DAC_CTRL:  rd_next = reg_data_t'(cur_cmd[ax]);
                    OFF_MOTOR_STATUS: begin
                        rd_next[BIT_AMP_ENABLED] = amp_enable[ax];
                        rd_next[CUR_W-1:0]       = cur_cmd[ax];
                    end
                    default:       rd_next = '0;
                endcase
            end
        end
    end

    // one cycle after raddr, no strobe
    always_ff @(posedge clk_125MHz) begin
        if (rst) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_next;
        end
    end

endmodule

// ==== rtl/qla_reg_top.sv ====
`timescale 1ns/1ps

module qla_reg_top
    import qla_addr_pkg::*;
    import qla_motor_pkg::*;
(
    input  logic       clk_125MHz,
    input  logic       rst,
    input  logic [3:0] board_id,
    input  logic       host_wen,
    input  logic       host_blk_wen,
    input  reg_addr_t  host_waddr,
    input  reg_data_t  host_wdata,
    input  logic       rt_wen,
    input  off_t       rt_waddr,
    input  reg_data_t  rt_wdata,
    input  reg_addr_t  reg_raddr,
    input  cur_vec_t   cur_fb,
    input  cur_vec_t   pot_fb,
    input  logic       cur_fb_valid,
    input  logic       dac_busy,
    output reg_data_t  reg_rdata,
    output logic       dac_update,
    output cur_vec_t   cur_cmd,
    output logic       pwr_enable,
    output axis_mask_t amp_enable
);

    // merged write bus
    logic       reg_wen;
    logic       blk_wen;
    reg_addr_t  reg_waddr;
    reg_data_t  reg_wdata;
    axis_mask_t safety_disable;   // status readback

    // ------------------------------
    // write path
    // ------------------------------
    rt_block_writer i_rt_block_writer (
        .clk_125MHz  (clk_125MHz),
        .rst         (rst),
        .host_wen    (host_wen),
        .host_blk_wen(host_blk_wen),
        .host_waddr  (host_waddr),
        .host_wdata  (host_wdata),
        .rt_wen      (rt_wen),
        .rt_waddr    (rt_waddr),
        .rt_wdata    (rt_wdata),
        .reg_wen     (reg_wen),
        .blk_wen     (blk_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata)
    );

    cur_cmd_regs i_cur_cmd_regs (
        .clk_125MHz(clk_125MHz),
        .rst       (rst),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .dac_busy  (dac_busy),
        .cur_cmd   (cur_cmd),
        .dac_update(dac_update)
    );

    board_regs i_board_regs (
        .clk_125MHz    (clk_125MHz),
        .rst           (rst),
        .reg_wen       (reg_wen),
        .reg_waddr     (reg_waddr),
        .reg_wdata     (reg_wdata),
        .cur_fb        (cur_fb),
        .cur_cmd       (cur_cmd),
        .cur_fb_valid  (cur_fb_valid),
        .safety_disable(safety_disable),
        .pwr_enable    (pwr_enable),
        .amp_enable    (amp_enable),
        .clear_disable ()                // used inside board_regs only
    );

    // ------------------------------
    // read path
    // ------------------------------
    reg_read_mux i_reg_read_mux (
        .clk_125MHz    (clk_125MHz),
        .rst           (rst),
        .reg_raddr     (reg_raddr),
        .board_id      (board_id),
        .pwr_enable    (pwr_enable),
        .amp_enable    (amp_enable),
        .safety_disable(safety_disable),
        .cur_fb        (cur_fb),
        .pot_fb        (pot_fb),
        .cur_cmd       (cur_cmd),
        .reg_rdata     (reg_rdata)
    );

endmodule

// ==== tb/qla_checker.sv ====
`timescale 1ns/1ps

module qla_checker
    import qla_addr_pkg::*;
    import qla_motor_pkg::*;
(
    input  logic       clk_125MHz,
    input  logic       rst,
    input  reg_data_t  reg_rdata,
    input  logic       dac_update,
    input  logic       dac_busy,
    input  axis_mask_t amp_enable,
    input  logic       pwr_enable,
    input  cur_vec_t   cur_cmd,
    input  logic       rd_chk,     // read address driven last edge
    input  logic       amp_chk,
    input  logic       cmd_chk,    // cur_cmd slot named by cmd_ax
    input  idx_t       cmd_ax,
    input  reg_data_t  exp_data,
    input  logic       win_open,   // dac_update counting window
    input  logic [1:0] exp_upd,
    input  logic       done,
    output int         err_cnt,
    output int         chk_cnt
);

    logic      rd_pend;   // rdata valid this edge
    reg_data_t rd_exp;
    logic      win_was;
    int        upd_cnt;
    logic      reported;

    initial begin
        err_cnt  = 0;
        chk_cnt  = 0;
        reported = 1'b0;
    end

    task automatic flag_error(input string msg);
        err_cnt++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endtask

    // ------------------------------
    // compare on every rising edge
    // ------------------------------
    always @(posedge clk_125MHz) begin
        if (rst) begin
            rd_pend <= 1'b0;
            win_was <= 1'b0;
            upd_cnt <= 0;
        end else begin
            rd_pend <= rd_chk;   // rdata registered one cycle after raddr
            rd_exp  <= exp_data;
            if (rd_pend) begin
                chk_cnt++;
                if (reg_rdata !== rd_exp)
                    flag_error($sformatf("read data %h, expected %h", reg_rdata, rd_exp));
            end
            if (amp_chk) begin
                chk_cnt++;
                if (amp_enable !== exp_data[NUM_CHANNELS-1:0])
                    flag_error($sformatf("amp_enable %b, expected %b",
                                         amp_enable, exp_data[NUM_CHANNELS-1:0]));
                if (pwr_enable !== exp_data[BIT_PWR_ENABLE])
                    flag_error($sformatf("pwr_enable %b, expected %b",
                                         pwr_enable, exp_data[BIT_PWR_ENABLE]));
            end
            if (cmd_chk) begin
                chk_cnt++;
                if (cur_cmd[cmd_ax] !== exp_data[CUR_W-1:0])
                    flag_error($sformatf("cur_cmd[%0d] %h, expected %h",
                                         cmd_ax, cur_cmd[cmd_ax], exp_data[CUR_W-1:0]));
            end
            if (dac_update && dac_busy)
                flag_error("dac_update pulsed while dac_busy high");
            // pulses per table entry
            if (win_open) begin
                upd_cnt <= upd_cnt + int'(dac_update);
            end else if (win_was) begin
                chk_cnt++;
                if (upd_cnt != int'(exp_upd))
                    flag_error($sformatf("%0d dac_update pulses, expected %0d",
                                         upd_cnt, exp_upd));
                upd_cnt <= 0;
            end
            win_was <= win_open;
            if (done && !reported) begin
                $display("checker: %0d checks, %0d errors", chk_cnt, err_cnt);
                reported = 1'b1;
            end
        end
    end

endmodule

// ==== tb/tb_qla_reg_top.sv ====
`timescale 1ns/1ps

module tb_qla_reg_top
    import qla_addr_pkg::*;
    import qla_motor_pkg::*;
();

    localparam int RST_CYCLES  = 5;
    localparam int IDLE_CYCLES = 8;    // covers replay + dac pulse latency
    localparam int ENTRY_MAX   = 16;   // cycles budgeted per table entry

    typedef enum logic [2:0] {OP_WR, OP_BLK, OP_RT, OP_RND, OP_FB, OP_RD, OP_RDADC, OP_AMP} op_t;

    typedef struct packed {
        op_t        op;
        reg_addr_t  addr;   // rt index or fb channel in 7:4
        reg_data_t  data;
        logic [3:0] busy;   // extra dac_busy cycles
        reg_data_t  exp;    // read data or amp enables in 3:0 and pwr_enable at 19
        logic [1:0] upd;    // dac_update pulses in this entry
    } entry_t;

    logic       clk_125MHz = 1'b0;
    logic       rst;
    logic [3:0] board_id;
    logic       host_wen;
    logic       host_blk_wen;
    reg_addr_t  host_waddr;
    reg_data_t  host_wdata;
    logic       rt_wen;
    off_t       rt_waddr;
    reg_data_t  rt_wdata;
    reg_addr_t  reg_raddr;
    cur_vec_t   cur_fb;
    cur_vec_t   pot_fb;
    logic       cur_fb_valid;
    logic       dac_busy;
    reg_data_t  reg_rdata;
    logic       dac_update;
    cur_vec_t   cur_cmd;
    logic       pwr_enable;
    axis_mask_t amp_enable;

    // driver to checker
    logic       rd_chk;
    logic       amp_chk;
    logic       cmd_chk;
    idx_t       cmd_ax;
    logic       win_open;
    logic       done;
    reg_data_t  exp_data;
    logic [1:0] exp_upd;
    int         err_cnt;
    int         chk_cnt;

    cur_vec_t    pot_m;   // last random values driven
    cur_vec_t    cur_m;
    logic [31:0] lfsr = 32'h66c8_8d5c;
    entry_t      tbl[$];
    int          cycles = 0;
    int          cycle_limit = 0;

    always #4 clk_125MHz = ~clk_125MHz;   // 125 MHz

    qla_reg_top i_qla_reg_top (.*);
    qla_checker i_qla_checker (.*);

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_cur(output cur_t v);
        v = '0;
        for (int i = 0; i < CUR_W; i++) begin
            lfsr = lfsr_step(lfsr);   // one step per bit
            v = {v[CUR_W-2:0], lfsr[0]};
        end
    endtask

    task automatic add_entry(op_t op, reg_addr_t addr, reg_data_t data, int busy,
                             reg_data_t exp, int upd);
        tbl.push_back(entry_t'{op, addr, data, 4'(busy), exp, 2'(upd)});
    endtask

    task automatic apply_entry(input entry_t e);
        idx_t     idx;
        cur_t     v;
        cur_vec_t fb;
        logic     cmd_rd;
        idx = idx_t'(e.addr[7:4] - 4'd1);   // axis of fb ops
        cmd_rd = (e.addr[15:12] == ADDR_MAIN) && (e.addr[3:0] == OFF_DAC_CTRL)
              && (e.addr[7:4] != 4'd0) && (e.addr[7:4] <= 4'(NUM_CHANNELS));
        @(posedge clk_125MHz);
        win_open <= 1'b1;
        exp_upd  <= e.upd;
        exp_data <= e.exp;
        dac_busy <= (e.busy != 4'd0);
        case (e.op)
            OP_WR, OP_BLK: begin
                host_wen     <= 1'b1;
                host_blk_wen <= (e.op == OP_BLK);
                host_waddr   <= e.addr;
                host_wdata   <= e.data;
            end
            OP_RT: begin
                rt_wen   <= 1'b1;
                rt_waddr <= e.addr[3:0];
                rt_wdata <= e.data;
            end
            OP_RND: begin
                for (int n = 0; n < NUM_CHANNELS; n++) begin
                    draw_cur(v);
                    pot_m = {v, pot_m[NUM_CHANNELS-1:1]};   // shift in from the top
                    draw_cur(v);
                    cur_m = {v, cur_m[NUM_CHANNELS-1:1]};
                end
                pot_fb <= pot_m;
                cur_fb <= cur_m;   // valid stays low so latches stay quiet
            end
            OP_FB: begin
                fb = {NUM_CHANNELS{CUR_MIDSCALE}};   // other axes at zero current
                fb[idx] = e.data[CUR_W-1:0];
                cur_fb       <= fb;
                cur_fb_valid <= 1'b1;
            end
            OP_RD: begin
                reg_raddr <= e.addr;
                rd_chk    <= 1'b1;
                cmd_chk   <= cmd_rd;   // dac control read also checks the cur_cmd port
                cmd_ax    <= idx;
            end
            OP_RDADC: begin
                reg_raddr <= e.addr;
                exp_data  <= {pot_m[idx], cur_m[idx]};   // pot in upper half
                rd_chk    <= 1'b1;
            end
            OP_AMP: amp_chk <= 1'b1;
            default: ;
        endcase
        @(posedge clk_125MHz);
        host_wen     <= 1'b0;
        host_blk_wen <= 1'b0;
        rt_wen       <= 1'b0;
        cur_fb_valid <= 1'b0;
        rd_chk       <= 1'b0;
        amp_chk      <= 1'b0;
        cmd_chk      <= 1'b0;
        repeat (e.busy) @(posedge clk_125MHz);
        dac_busy <= 1'b0;
        repeat (IDLE_CYCLES) @(posedge clk_125MHz);
        win_open <= 1'b0;
    endtask

    // ------------------------------
    // stimulus table
    // ------------------------------
    task automatic fill_table();
        // single host write without a dac kick
        add_entry(OP_WR,    16'h0021, 32'h0000_1234, 0, 32'h0,         0);
        add_entry(OP_RD,    16'h0021, 32'h0,         0, 32'h0000_1234, 0);
        add_entry(OP_RD,    16'h002c, 32'h0,         0, 32'h0000_1234, 0);
        // block writes where the second one waits out dac_busy
        add_entry(OP_BLK,   16'h0031, 32'h0000_9000, 0, 32'h0,         1);
        add_entry(OP_BLK,   16'h0041, 32'h0000_7000, 5, 32'h0,         1);
        add_entry(OP_RD,    16'h0031, 32'h0,         0, 32'h0000_9000, 0);
        add_entry(OP_RD,    16'h0041, 32'h0,         0, 32'h0000_7000, 0);
        // real-time block with upper halves ignored
        add_entry(OP_RT,    16'h0000, 32'habcd_8100, 0, 32'h0,         0);
        add_entry(OP_RT,    16'h0001, 32'h5555_8200, 0, 32'h0,         0);
        add_entry(OP_RT,    16'h0002, 32'h0000_7e00, 0, 32'h0,         0);
        add_entry(OP_RT,    16'h0003, 32'hffff_8400, 0, 32'h0,         1);
        add_entry(OP_RD,    16'h0011, 32'h0,         0, 32'h0000_8100, 0);
        add_entry(OP_RD,    16'h0021, 32'h0,         0, 32'h0000_8200, 0);
        add_entry(OP_RD,    16'h0031, 32'h0,         0, 32'h0000_7e00, 0);
        add_entry(OP_RD,    16'h0041, 32'h0,         0, 32'h0000_8400, 0);
        // adc data and the empty corners of the map
        add_entry(OP_RND,   16'h0000, 32'h0,         0, 32'h0,         0);
        add_entry(OP_RDADC, 16'h0010, 32'h0,         0, 32'h0,         0);
        add_entry(OP_RDADC, 16'h0020, 32'h0,         0, 32'h0,         0);
        add_entry(OP_RDADC, 16'h0030, 32'h0,         0, 32'h0,         0);
        add_entry(OP_RDADC, 16'h0040, 32'h0,         0, 32'h0,         0);
        add_entry(OP_RD,    16'h0015, 32'h0,         0, 32'h0,         0);
        add_entry(OP_RD,    16'h1011, 32'h0,         0, 32'h0,         0);
        add_entry(OP_RD,    16'h0051, 32'h0,         0, 32'h0,         0);
        add_entry(OP_RD,    16'h0001, 32'h0,         0, 32'h0,         0);
        add_entry(OP_RD,    16'h0000, 32'h0,         0, 32'h0900_0000, 0);
        // enables then an overcurrent on axis 2 (limit 2*0x200 + 0x400)
        add_entry(OP_WR,    16'h0000, 32'h0008_000f, 0, 32'h0,         0);
        add_entry(OP_AMP,   16'h0000, 32'h0,         0, 32'h0008_000f, 0);
        add_entry(OP_RD,    16'h0000, 32'h0,         0, 32'h0908_000f, 0);
        add_entry(OP_FB,    16'h0020, 32'h0000_8800, 0, 32'h0,         0);   // at limit
        add_entry(OP_AMP,   16'h0000, 32'h0,         0, 32'h0008_000f, 0);
        add_entry(OP_FB,    16'h0020, 32'h0000_77ff, 0, 32'h0,         0);   // one past
        add_entry(OP_AMP,   16'h0000, 32'h0,         0, 32'h0008_000d, 0);
        add_entry(OP_RD,    16'h0000, 32'h0,         0, 32'h0908_020d, 0);
        add_entry(OP_RD,    16'h002c, 32'h0,         0, 32'h0000_8200, 0);
        add_entry(OP_RD,    16'h001c, 32'h0,         0, 32'h1000_8100, 0);
        // rewrite re-arms the latch
        add_entry(OP_WR,    16'h0000, 32'h0008_000f, 0, 32'h0,         0);
        add_entry(OP_AMP,   16'h0000, 32'h0,         0, 32'h0008_000f, 0);
        add_entry(OP_RD,    16'h0000, 32'h0,         0, 32'h0908_000f, 0);
        add_entry(OP_RD,    16'h002c, 32'h0,         0, 32'h1000_8200, 0);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst          = 1'b1;
        board_id     = 4'h9;
        host_wen     = 1'b0;
        host_blk_wen = 1'b0;
        host_waddr   = '0;
        host_wdata   = '0;
        rt_wen       = 1'b0;
        rt_waddr     = '0;
        rt_wdata     = '0;
        reg_raddr    = '0;
        cur_fb       = {NUM_CHANNELS{CUR_MIDSCALE}};
        pot_fb       = {NUM_CHANNELS{CUR_MIDSCALE}};
        pot_m        = '0;
        cur_m        = '0;
        cur_fb_valid = 1'b0;
        dac_busy     = 1'b0;
        rd_chk       = 1'b0;
        amp_chk      = 1'b0;
        cmd_chk      = 1'b0;
        cmd_ax       = '0;
        win_open     = 1'b0;
        done         = 1'b0;
        exp_data     = '0;
        exp_upd      = '0;
        fill_table();
        cycle_limit = tbl.size() * ENTRY_MAX + RST_CYCLES;
        repeat (RST_CYCLES) @(posedge clk_125MHz);
        rst <= 1'b0;
        foreach (tbl[i]) begin
            apply_entry(tbl[i]);
        end
        @(posedge clk_125MHz);
        done <= 1'b1;   // checker closes its last window first
        repeat (2) @(posedge clk_125MHz);
        if (err_cnt == 0 && chk_cnt > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // hang guard
    always @(posedge clk_125MHz) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("timeout: table not finished after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

endmodule

// ==== project.f ====
rtl/qla_addr_pkg.sv
rtl/qla_motor_pkg.sv
rtl/safety_check.sv
rtl/rt_block_writer.sv
rtl/cur_cmd_regs.sv
rtl/board_regs.sv
rtl/reg_read_mux.sv
rtl/qla_reg_top.sv
tb/qla_checker.sv
tb/tb_qla_reg_top.sv

// ==== Makefile ====
# Verilator flow for the register core testbench

TOP       ?= tb_qla_reg_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
